// ==== src.f ====
verilog/fetch_pkg.sv
verilog/fetch_request.sv
verilog/fetch_queue_slot.sv
verilog/instr_align.sv
verilog/fetch_frontend.sv
bench/fetch_mem_model.sv
bench/tb_fetch_frontend.sv

// ==== Makefile ====
simulate:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module tb_fetch_frontend
	./obj_dir/Vtb_fetch_frontend | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: simulate clean

// ==== bench/tb_fetch_frontend.sv ====
// Fetch front end testbench
`default_nettype none

module tb_fetch_frontend
	import fetch_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// one row is an optional jump, a halfword count and a decode stall density
	typedef struct packed {
		logic              jump;
		logic [W_ADDR-1:0] target;
		logic [15:0]       count;
		logic [1:0]        density;
	} stim_row_t;

	logic              clk;
	logic              rst_n;
	logic [W_ADDR-1:0] mem_addr;
	logic              mem_addr_vld;
	logic              mem_addr_rdy;
	logic [W_DATA-1:0] mem_data;
	logic              mem_data_err;
	logic              mem_data_vld;
	logic [W_ADDR-1:0] jump_target;
	logic              jump_target_vld;
	logic              jump_target_rdy;
	logic [31:0]       cir;
	logic [1:0]        cir_vld;
	logic [1:0]        cir_use;
	logic [1:0]        cir_err;
	logic [3:0]        mem_rand;
	logic [15:0]       lfsr_state = 16'd37370;
	logic [W_ADDR-1:0] exp_addr;
	logic              first_seen = 1'b0;
	logic              addr_held;
	logic [W_ADDR-1:0] held_addr;
	int                errors = 0;
	int                timeouts = 0;
	stim_row_t         rows [8];

	fetch_frontend dut0 (.*);

	fetch_mem_model mem0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_addr     (mem_addr),
		.mem_addr_vld (mem_addr_vld),
		.mem_addr_rdy (mem_addr_rdy),
		.mem_data     (mem_data),
		.mem_data_err (mem_data_err),
		.mem_data_vld (mem_data_vld),
		.rand_bits    (mem_rand)
	);

	// ------------------------------------------------------------
	// reference rules and helpers

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [3:0] random_bits(input int n);
		logic [3:0] bits;
		bits = '0;
		repeat (n) begin
			bits       = {bits[2:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return bits;
	endfunction

	// 32-bit instructions start at halfword 2 of every 8-byte group
	function automatic logic [W_HW-1:0] expected_halfword(input logic [W_ADDR-1:0] a);
		logic [W_HW-1:0] v;
		v      = a[16:1];
		v[1:0] = (a[2:1] == 2'b10) ? 2'b11 : 2'b01;
		return v;
	endfunction

	function automatic logic expected_err(input logic [W_ADDR-1:0] a);
		return a[7:6] == 2'b11;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// the jump is raised only while rdy is high so one cycle takes it
	task automatic apply_jump(input logic [W_ADDR-1:0] target);
		int waited;
		waited = 0;
		while (!jump_target_rdy && waited < 50) begin
			waited++;
			@(negedge clk);
		end
		if (!jump_target_rdy) begin
			$display("timeout: jump_target_rdy stayed low for %0d cycles", waited);
			timeouts++;
		end else begin
			jump_target     = target;
			jump_target_vld = 1'b1;
			@(negedge clk);
			jump_target_vld = 1'b0;
			// the window is empty right after the jump edge
			check_value("cir_vld", 32'(cir_vld), 32'h0);
		end
	endtask

	// decode takes one instruction per cycle unless the random stall hits
	task automatic consume_stream(input logic [15:0] count, input logic [1:0] density);
		int         taken;
		int         idle;
		logic [1:0] use_now;
		logic [3:0] r;
		taken = 0;
		idle  = 0;
		while (taken < int'(count) && idle <= 200) begin
			check_value("cir_vld above 2", 32'(cir_vld == 2'd3), 32'h0);
			r       = random_bits(2);
			use_now = 2'd0;
			if (r[1:0] >= density && cir_vld != 2'd0) begin
				if (cir[1:0] != 2'b11) begin
					use_now = 2'd1;
				end else if (cir_vld == 2'd2) begin
					use_now = 2'd2;
				end
			end
			if (use_now != 2'd0) begin
				check_value("cir[15:0]", 32'(cir[15:0]), 32'(expected_halfword(exp_addr)));
				check_value("cir_err[0]", 32'(cir_err[0]), 32'(expected_err(exp_addr)));
			end
			if (use_now == 2'd2) begin
				check_value("cir[31:16]", 32'(cir[31:16]),
					32'(expected_halfword(exp_addr + 32'd2)));
				check_value("cir_err[1]", 32'(cir_err[1]), 32'(expected_err(exp_addr + 32'd2)));
			end
			cir_use  = use_now;
			exp_addr = exp_addr + {29'd0, use_now, 1'b0};
			taken    = taken + int'(use_now);
			idle     = (use_now == 2'd0) ? idle + 1 : 0;
			@(negedge clk);
		end
		cir_use = 2'd0;
		if (idle > 200) begin
			$display("timeout: decode window made no progress at address %h", exp_addr);
			timeouts++;
		end
	endtask

	// ------------------------------------------------------------
	// clock, bus monitor and stimulus

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// the first address taken by the bus must be the reset vector and an
	// address phase that was not taken stays on the bus and blocks jumps
	initial begin
		mem_rand  = 4'h0;
		addr_held = 1'b0;
		held_addr = '0;
		forever begin
			@(posedge clk);
			if (rst_n && !first_seen && mem_addr_vld && mem_addr_rdy) begin
				check_value("mem_addr", mem_addr, RESET_VECTOR);
				first_seen = 1'b1;
			end
			if (rst_n && addr_held) begin
				check_value("mem_addr_vld", 32'(mem_addr_vld), 32'h1);
				check_value("mem_addr", mem_addr, held_addr);
				check_value("jump_target_rdy", 32'(jump_target_rdy), 32'h0);
			end else if (rst_n) begin
				check_value("jump_target_rdy", 32'(jump_target_rdy), 32'h1);
			end
			addr_held = rst_n && mem_addr_vld && !mem_addr_rdy;
			held_addr = mem_addr;
			mem_rand  = random_bits(4);
		end
	end

	initial begin
		rst_n           = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_use         = 2'd0;
		exp_addr        = RESET_VECTOR;
		// 0xc0 to 0xff is the error region and 0x232 and 0xca are odd halfwords
		rows[0] = '{1'b0, RESET_VECTOR, 16'd40, 2'd0};
		rows[1] = '{1'b1, 32'h0000_0100, 16'd30, 2'd1};
		rows[2] = '{1'b1, 32'h0000_0232, 16'd25, 2'd2};
		rows[3] = '{1'b1, 32'h0000_00c0, 16'd40, 2'd1};
		rows[4] = '{1'b1, 32'h0000_1008, 16'd60, 2'd3};
		rows[5] = '{1'b1, 32'h0000_00ca, 16'd20, 2'd3};
		rows[6] = '{1'b1, 32'h0000_2004, 16'd50, 2'd3};
		rows[7] = '{1'b1, 32'h0000_0000, 16'd30, 2'd0};
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		#1;
		// still in the holdoff cycle
		check_value("mem_addr_vld", 32'(mem_addr_vld), 32'h0);
		@(negedge clk);
		for (int i = 0; i < 8 && timeouts == 0; i++) begin
			if (rows[i].jump) begin
				apply_jump(rows[i].target);
			end
			exp_addr = rows[i].target;
			if (timeouts == 0) begin
				consume_stream(rows[i].count, rows[i].density);
			end
		end
		if (!first_seen) begin
			$display("the memory bus never accepted an address");
			errors++;
		end
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/fetch_mem_model.sv ====
// Instruction memory model
`default_nettype none

module fetch_mem_model
	import fetch_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	input  wire  [W_ADDR-1:0] mem_addr,
	input  wire               mem_addr_vld,
	output logic              mem_addr_rdy,
	output logic [W_DATA-1:0] mem_data,
	output logic              mem_data_err,
	output logic              mem_data_vld,
	input  wire  [3:0]        rand_bits
);
	timeunit 1ns;
	timeprecision 1ps;

	// accepted word addresses and the cycle in which each one is answered
	logic [W_ADDR-1:0] addr_q [$];
	int                due_q [$];
	int                cyc;
	int                last_due;
	int                next_delay;

	// contents rule with the low two bits marking the instruction length
	function automatic logic [W_HW-1:0] stored_halfword(input logic [W_ADDR-1:0] a);
		logic [W_HW-1:0] v;
		v      = a[16:1];
		v[1:0] = (a[2:1] == 2'b10) ? 2'b11 : 2'b01;
		return v;
	endfunction

	initial begin
		mem_addr_rdy = 1'b0;
		mem_data     = '0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		cyc          = 0;
		last_due     = 0;
		next_delay   = 1;
		forever begin
			// ----------------------------------------------------------
			// the rising edge sees what the bus did in the cycle before it
			@(posedge clk);
			cyc = cyc + 1;
			if (!rst_n) begin
				addr_q.delete();
				due_q.delete();
				last_due = cyc;
			end else begin
				if (mem_data_vld) begin
					void'(addr_q.pop_front());
					void'(due_q.pop_front());
				end
				if (mem_addr_vld && mem_addr_rdy) begin
					addr_q.push_back({mem_addr[W_ADDR-1:2], 2'b00});
					// answers never overtake each other
					if (cyc + next_delay > last_due) begin
						last_due = cyc + next_delay;
					end else begin
						last_due = last_due + 1;
					end
					due_q.push_back(last_due);
				end
			end
			// ----------------------------------------------------------
			// the falling edge sets up the bus for the next rising edge
			@(negedge clk);
			mem_addr_rdy = (rand_bits[1:0] != 2'b00);
			next_delay   = 1 + int'(rand_bits[3:2]) % 3;
			if (due_q.size() > 0 && due_q[0] == cyc + 1) begin
				mem_data_vld = 1'b1;
				mem_data     = {stored_halfword(addr_q[0] + 32'd2), stored_halfword(addr_q[0])};
				// words with address bits 7:6 set report a bus error
				mem_data_err = (addr_q[0][7:6] == 2'b11);
			end else begin
				mem_data_vld = 1'b0;
				mem_data     = '0;
				mem_data_err = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fetch_frontend.sv ====
// Instruction fetch front end
`default_nettype none

module fetch_frontend
	import fetch_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,

	// memory bus address phase
	// once raised the address and its valid hold until the cycle after rdy
	output logic [W_ADDR-1:0] mem_addr,
	output logic              mem_addr_vld,
	input  wire               mem_addr_rdy,

	// memory bus data phase with no back-pressure
	input  wire  [W_DATA-1:0] mem_data,
	input  wire               mem_data_err,
	input  wire               mem_data_vld,

	// jump and flush requests from the core
	input  wire  [W_ADDR-1:0] jump_target,
	input  wire               jump_target_vld,
	output logic              jump_target_rdy,

	// decode window and the number of halfwords decode takes from it
	output logic [31:0]       cir,
	output logic [1:0]        cir_vld,
	input  wire  [1:0]        cir_use,
	output logic [1:0]        cir_err
);

	logic        jump_now;
	fetch_word_t bus_word;
	logic        bus_word_vld;
	logic        queue_push;
	logic        queue_pop;
	logic        queue_full;
	logic        queue_almost_full;

	// the chain has one extra entry above the top slot that is always empty
	fetch_word_t slot_word [QUEUE_DEPTH+1];
	logic        slot_vld [QUEUE_DEPTH+1];
	logic        slot_below_vld [QUEUE_DEPTH];

	// ----------------------------------------------------------
	// request generation and bus tracking

	fetch_request u_request (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.mem_data          (mem_data),
		.mem_data_err      (mem_data_err),
		.mem_data_vld      (mem_data_vld),
		.jump_target       (jump_target),
		.jump_target_vld   (jump_target_vld),
		.jump_target_rdy   (jump_target_rdy),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full),
		.jump_now          (jump_now),
		.bus_word          (bus_word),
		.bus_word_vld      (bus_word_vld)
	);

	// ----------------------------------------------------------
	// prefetch queue

	assign slot_word[QUEUE_DEPTH] = '0;
	assign slot_vld[QUEUE_DEPTH]  = 1'b0;

	// the queue is compact so its fill state is read from the valids
	assign queue_full        = slot_vld[QUEUE_DEPTH-1];
	assign queue_almost_full = slot_vld[QUEUE_DEPTH-2];

	for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_slot
		// slot 0 behaves as if an occupied slot sat below it
		if (i == 0) begin : g_bottom
			assign slot_below_vld[i] = 1'b1;
		end else begin : g_upper
			assign slot_below_vld[i] = slot_vld[i-1];
		end

		fetch_queue_slot u_slot (
			.clk        (clk),
			.rst_n      (rst_n),
			.jump_now   (jump_now),
			.push       (queue_push),
			.pop        (queue_pop),
			.in_word    (bus_word),
			.above_word (slot_word[i+1]),
			.above_vld  (slot_vld[i+1]),
			.below_vld  (slot_below_vld[i]),
			.word       (slot_word[i]),
			.vld        (slot_vld[i])
		);
	end

	// ----------------------------------------------------------
	// instruction buffer and decode window

	instr_align u_align (
		.clk          (clk),
		.rst_n        (rst_n),
		.jump_now     (jump_now),
		.bus_word     (bus_word),
		.bus_word_vld (bus_word_vld),
		.head_word    (slot_word[0]),
		.head_vld     (slot_vld[0]),
		.queue_push   (queue_push),
		.queue_pop    (queue_pop),
		.cir          (cir),
		.cir_vld      (cir_vld),
		.cir_use      (cir_use),
		.cir_err      (cir_err)
	);

endmodule

`default_nettype wire

// ==== verilog/instr_align.sv ====
// Instruction buffer and aligner
`default_nettype none

module instr_align
	import fetch_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              jump_now,
	input  wire fetch_word_t bus_word,
	input  wire              bus_word_vld,
	input  wire fetch_word_t head_word,
	input  wire              head_vld,
	output logic             queue_push,
	output logic             queue_pop,
	output logic [31:0]      cir,
	output logic [1:0]       cir_vld,
	input  wire  [1:0]       cir_use,
	output logic [1:0]       cir_err
);

	// three halfwords let the window sit on either halfword of a word
	// and the lower two of them form the decode window
	ibuf_slot_t [2:0] buf_q;
	ibuf_slot_t [2:0] buf_shifted;
	ibuf_slot_t [2:0] buf_next;
	ibuf_slot_t [1:0] fetch_aligned;
	fetch_word_t      src_word;
	logic             src_vld;
	logic             room;
	logic [1:0]       buf_level;
	logic [1:0]       level_no_fetch;
	logic [1:0]       fill_amount;
	logic [1:0]       level_next;

	// ----------------------------------------------------------
	// fetch source

	// live bus data bypasses the queue only when the queue is empty
	assign src_word = head_vld ? head_word : bus_word;
	assign src_vld  = head_vld || bus_word_vld;

	// with only the upper half valid it is placed at the lowest position
	always_comb begin
		fetch_aligned[1].hw  = src_word.data[W_DATA-1:W_HW];
		fetch_aligned[1].err = src_word.err;
		fetch_aligned[0].err = src_word.err;
		if (src_word.hwvld[0]) begin
			fetch_aligned[0].hw = src_word.data[W_HW-1:0];
		end else begin
			fetch_aligned[0].hw = src_word.data[W_DATA-1:W_HW];
		end
	end

	// ----------------------------------------------------------
	// shift and refill

	// unused halfwords drop down by the amount decode took this cycle
	always_comb begin
		buf_shifted = buf_q;
		if (cir_use[1]) begin
			buf_shifted[0] = buf_q[2];
		end else if (cir_use[0]) begin
			buf_shifted[0] = buf_q[1];
			buf_shifted[1] = buf_q[2];
		end
	end

	assign level_no_fetch = buf_level - cir_use;

	// a whole word fits with at most one halfword left and a half word with two
	assign room = level_no_fetch <= (&src_word.hwvld ? 2'd1 : 2'd2);

	// a word leaves the queue when it fits and bus data that cannot
	// go straight into the buffer is parked in the queue
	assign queue_pop  = room && head_vld;
	assign queue_push = bus_word_vld && !(room && !head_vld);

	// fresh halfwords go on top of whatever is left after the shift
	always_comb begin
		buf_next = buf_shifted;
		if (room) begin
			case (level_no_fetch)
				2'd0: begin
					buf_next[0] = fetch_aligned[0];
					buf_next[1] = fetch_aligned[1];
				end
				2'd1: begin
					buf_next[1] = fetch_aligned[0];
					buf_next[2] = fetch_aligned[1];
				end
				2'd2: begin
					buf_next[2] = fetch_aligned[0];
				end
				default: begin
					buf_next = buf_shifted;
				end
			endcase
		end
	end

	assign fill_amount = (room && src_vld) ? (&src_word.hwvld ? 2'd2 : 2'd1) : 2'd0;

	// a jump empties the buffer so the window is invalid on the next cycle
	assign level_next = jump_now ? 2'd0 : level_no_fetch + fill_amount;

	// ----------------------------------------------------------
	// registers and decode window

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld   <= 2'd0;
			buf_q     <= '0;
		end else begin
			buf_level <= level_next;
			// the window shows at most two halfwords even with three stored
			cir_vld   <= level_next & ~(level_next >> 1);
			buf_q     <= buf_next;
		end
	end

	assign cir     = {buf_q[1].hw, buf_q[0].hw};
	assign cir_err = {buf_q[1].err, buf_q[0].err};

	// ----------------------------------------------------------
	// checks

	// decode may only take halfwords that the window offered
	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld);

	// at most one word comes in per cycle so a jump from empty to three
	// can only come from the level wrapping below zero
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		(buf_level == 2'd0) |=> (buf_level != 2'd3));

endmodule

`default_nettype wire

// ==== verilog/fetch_queue_slot.sv ====
// Prefetch queue slot
`default_nettype none

module fetch_queue_slot
	import fetch_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              jump_now,
	input  wire              push,
	input  wire              pop,
	input  wire fetch_word_t in_word,
	input  wire fetch_word_t above_word,
	input  wire              above_vld,
	input  wire              below_vld,
	output fetch_word_t      word,
	output logic             vld
);

	logic [W_DATA-1:0] data_q;
	logic              err_q;
	logic [1:0]        hwvld_q;
	logic [1:0]        hwvld_next;
	logic              load;

	// a slot holds a word as long as either halfword is still wanted
	assign vld  = |hwvld_q;
	assign word = '{data: data_q, hwvld: hwvld_q, err: err_q};

	// the payload moves on every pop and fills an empty slot on a push
	// and anything it picks up while not valid is never looked at
	assign load = pop || (push && !vld);

	always_ff @(posedge clk) begin
		if (load) begin
			data_q <= above_vld ? above_word.data : in_word.data;
			err_q  <= above_vld ? above_word.err : in_word.err;
		end
	end

	// the tags decide which slot really took the word
	always_comb begin
		if (jump_now) begin
			hwvld_next = 2'b00;
		end else if (above_vld && pop) begin
			// the word above moves down into this slot
			hwvld_next = above_word.hwvld;
		end else if (vld && pop) begin
			// this is the top valid slot so a push on the same cycle ends here
			hwvld_next = push ? in_word.hwvld : 2'b00;
		end else if (vld) begin
			hwvld_next = hwvld_q;
		end else if (push && !pop && below_vld) begin
			// lowest empty slot takes the bus word
			hwvld_next = in_word.hwvld;
		end else begin
			hwvld_next = 2'b00;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hwvld_q <= 2'b00;
		end else begin
			hwvld_q <= hwvld_next;
		end
	end

	// the queue stays compact so slot 0 always holds the oldest word
	a_compact: assert property (@(posedge clk) disable iff (!rst_n)
		vld |-> below_vld);

endmodule

`default_nettype wire

// ==== verilog/fetch_request.sv ====
// Fetch request generator
`default_nettype none

module fetch_request
	import fetch_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n,
	output logic [W_ADDR-1:0] mem_addr,
	output logic              mem_addr_vld,
	input  wire               mem_addr_rdy,
	input  wire  [W_DATA-1:0] mem_data,
	input  wire               mem_data_err,
	input  wire               mem_data_vld,
	input  wire  [W_ADDR-1:0] jump_target,
	input  wire               jump_target_vld,
	output logic              jump_target_rdy,
	input  wire               queue_full,
	input  wire               queue_almost_full,
	output logic              jump_now,
	output fetch_word_t       bus_word,
	output logic              bus_word_vld
);

	req_state_t        state_q;
	logic [W_ADDR-1:0] fetch_addr;
	logic [W_ADDR-1:0] jump_word;
	logic              mem_addr_hold;
	logic              addr_req;
	logic              addr_accept;
	logic              fetch_stall;
	logic              aph_odd;
	logic              aph_odd_q;
	logic              odd_idx;
	logic [1:0]        inflight_odd;
	logic [1:0]        inflight_odd_next;
	logic [1:0]        pending_fetches;
	logic [1:0]        flush_ctr;

	// ----------------------------------------------------------
	// address phase

	// the bus sees no request in the first cycle out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_HOLDOFF;
		end else begin
			state_q <= ST_RUN;
		end
	end

	// a jump cannot be taken while an address is held on the bus
	assign jump_target_rdy = !mem_addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;
	assign jump_word       = {jump_target[W_ADDR-1:2], 2'b00};

	// the counts are registered so a full queue must stop fetch early
	// because up to two words can still be on their way back
	assign fetch_stall = queue_full
		|| (queue_almost_full && |pending_fetches)
		|| (pending_fetches > 2'd1);

	always_comb begin
		mem_addr = fetch_addr;
		addr_req = 1'b1;
		if (mem_addr_hold) begin
			// a held request keeps the address that was first raised
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			// a jump goes straight out unless the bus already has two in flight
			mem_addr = jump_word;
			addr_req = pending_fetches < 2'd2;
		end else if (fetch_stall) begin
			addr_req = 1'b0;
		end
	end

	assign mem_addr_vld = addr_req && (state_q == ST_RUN);
	assign addr_accept  = mem_addr_vld && mem_addr_rdy;

	// the fetch that goes out with a jump takes the target alignment
	// and a later one takes the alignment saved when the jump was taken
	assign aph_odd = jump_now ? jump_target[1] : aph_odd_q;

	// ----------------------------------------------------------
	// fetch address and bus tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr      <= RESET_VECTOR;
			mem_addr_hold   <= 1'b0;
			aph_odd_q       <= 1'b0;
			pending_fetches <= 2'd0;
			flush_ctr       <= 2'd0;
			inflight_odd    <= 2'b00;
		end else begin
			mem_addr_hold   <= mem_addr_vld && !mem_addr_rdy;
			pending_fetches <= pending_fetches + {1'b0, addr_accept} - {1'b0, mem_data_vld};
			inflight_odd    <= inflight_odd_next;
			if (jump_now) begin
				// fetch_addr moves past the target if the target went out already
				fetch_addr <= addr_accept ? jump_word + W_ADDR'(4) : jump_word;
				aph_odd_q  <= jump_target[1] && !addr_accept;
				// every word still owed by the bus belongs to the old stream
				flush_ctr  <= pending_fetches - {1'b0, mem_data_vld};
			end else begin
				if (addr_accept) begin
					fetch_addr <= fetch_addr + W_ADDR'(4);
					aph_odd_q  <= 1'b0;
				end
				if (|flush_ctr && mem_data_vld) begin
					flush_ctr <= flush_ctr - 2'd1;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// alignment tags for the words in flight

	// entry 0 belongs to the oldest fetch and a new one lands just above
	// the last entry still in flight after this cycle's return
	assign odd_idx = pending_fetches[0] && !mem_data_vld;

	always_comb begin
		inflight_odd_next = inflight_odd;
		if (mem_data_vld) begin
			inflight_odd_next = {1'b0, inflight_odd[1]};
		end
		if (addr_accept) begin
			inflight_odd_next[odd_idx] = aph_odd;
		end
	end

	// the lower halfword of the word holding an odd jump target is skipped
	assign bus_word = '{
		data:  mem_data,
		hwvld: {1'b1, !inflight_odd[0]},
		err:   mem_data_err
	};

	// returns that belong to a flushed stream never leave this block
	assign bus_word_vld = mem_data_vld && (flush_ctr == 2'd0);

	// ----------------------------------------------------------
	// checks against the memory side

	a_flush_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		flush_ctr <= pending_fetches);

	a_pending_max: assert property (@(posedge clk) disable iff (!rst_n)
		pending_fetches < 2'd3);

	a_no_orphan_data: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_data_vld && (pending_fetches == 2'd0)));

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
// Fetch front end definitions
`default_nettype none

package fetch_pkg;

	// ----------------------------------------------------------
	// widths and sizes

	// byte address width of the instruction bus
	localparam int W_ADDR = 32;

	// the bus always moves one naturally aligned word per fetch
	localparam int W_DATA = 32;

	// compressed instructions are built from halfwords of this width
	localparam int W_HW = 16;

	// two slots are the least that keeps full fetch throughput
	// when decode stalls with two fetches still on the bus
	localparam int QUEUE_DEPTH = 2;

	// the first fetch after reset goes to this address
	localparam logic [W_ADDR-1:0] RESET_VECTOR = 32'h0000_0000;

	// ----------------------------------------------------------
	// data carried between the blocks

	// a word returned by the bus together with its tags
	// hwvld has one bit per halfword and the lower bit is clear for
	// the first word after a jump to the upper halfword of a word
	// a bus error covers the whole word and so both halfwords
	typedef struct packed {
		logic [W_DATA-1:0] data;
		logic [1:0]        hwvld;
		logic              err;
	} fetch_word_t;

	// one halfword of the instruction buffer with its error tag
	typedef struct packed {
		logic [W_HW-1:0] hw;
		logic            err;
	} ibuf_slot_t;

	// ----------------------------------------------------------
	// request generator state

	// the generator sits in ST_HOLDOFF for one cycle after reset
	// and issues requests only from ST_RUN onwards
	typedef enum logic {
		ST_HOLDOFF,
		ST_RUN
	} req_state_t;

endpackage

`default_nettype wire
